//--- logic/rv32i_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types, opcodes and pipeline register layouts of the RV32I core
// Imported by every RTL module and by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv32i_pkg;

  typedef logic [31:0] word_t;     // Data, address or instruction word
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_op_t;
  typedef logic [2:0]  fwd_sel_t;  // Source of a decode-stage operand

  localparam word_t PC_STEP = 32'd4;

  // ALU operation codes
  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SLL = 3'd5;

  // Opcode field, inst[6:0]
  localparam logic [6:0] OP_R       = 7'b0110011;
  localparam logic [6:0] OP_I_ARITH = 7'b0010011;
  localparam logic [6:0] OP_I_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_S       = 7'b0100011;
  localparam logic [6:0] OP_U_LUI   = 7'b0110111;

  localparam fwd_sel_t FWD_RF       = 3'd0;  // Register file read
  localparam fwd_sel_t FWD_EX       = 3'd1;  // ALU output in execute
  localparam fwd_sel_t FWD_MEM_LOAD = 3'd2;  // Load data in memory stage
  localparam fwd_sel_t FWD_MEM_ALU  = 3'd3;
  localparam fwd_sel_t FWD_WB       = 3'd4;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    use_imm;   // Second ALU operand is the immediate
    logic    lui;       // First ALU operand forced to zero
    alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
  } id_ex_t;

  typedef struct packed {
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    reg_addr_t rd;
    word_t     alu_result;  // Also the data memory address
    word_t     store_data;
  } ex_mem_t;

  // Load data travels beside this register
  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    reg_addr_t rd;
    word_t     result;
  } mem_wb_t;

  typedef struct packed {
    logic  write;  // Single-cycle strobe
    word_t addr;
    word_t wdata;
  } dmem_req_t;

endpackage

//--- logic/rv32i_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode-stage instruction decoder, combinational
// Produces the control bundle and the one immediate that execute consumes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_decoder (
  input  rv32i_pkg::word_t inst,
  output rv32i_pkg::ctrl_t ctrl,
  output rv32i_pkg::word_t imm
);
  import rv32i_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       r_known;   // add, sub, and, or

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign r_known = ((funct7 == 7'b0000000) &&
                    (funct3 == 3'b000 || funct3 == 3'b110 || funct3 == 3'b111)) ||
                   ((funct7 == 7'b0100000) && (funct3 == 3'b000));

  always_comb
  begin
    ctrl = '0;   // Anything unrecognized becomes a bubble
    imm  = '0;
    case (opcode)
      OP_R:
      begin
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = ALU_ADD;
          10'b0100000_000: ctrl.alu_op = ALU_SUB;
          10'b0000000_111: ctrl.alu_op = ALU_AND;
          10'b0000000_110: ctrl.alu_op = ALU_OR;
          default:         ctrl = '0;
        endcase
      end
      OP_I_ARITH:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        imm            = {{20{inst[31]}}, inst[31:20]};
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_ADD;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b110:  ctrl.alu_op = ALU_OR;
          3'b111:  ctrl.alu_op = ALU_AND;
          3'b001:  ctrl.alu_op = ALU_SLL;   // shamt sits in imm[4:0]
          default: ctrl = '0;
        endcase
        if (funct3 == 3'b001 && funct7 != 7'b0000000)
          ctrl = '0;
      end
      OP_I_LOAD:
      begin
        ctrl = '{reg_write: 1'b1, mem_read: 1'b1, mem_write: 1'b0,
                 use_imm: 1'b1, lui: 1'b0, alu_op: ALU_ADD};
        imm  = {{20{inst[31]}}, inst[31:20]};
      end
      OP_S:
      begin
        ctrl = '{reg_write: 1'b0, mem_read: 1'b0, mem_write: 1'b1,
                 use_imm: 1'b1, lui: 1'b0, alu_op: ALU_ADD};
        imm  = {{20{inst[31]}}, inst[31:25], inst[11:7]};  // S-type split field
      end
      OP_U_LUI:
      begin
        ctrl = '{reg_write: 1'b1, mem_read: 1'b0, mem_write: 1'b0,
                 use_imm: 1'b1, lui: 1'b1, alu_op: ALU_ADD};
        imm  = {inst[31:12], 12'b0};
      end
      default: ;
    endcase
  end

  // Unsupported R-type encodings must never reach the register file
  always_comb
  begin
    if (opcode == OP_R && !r_known)
      assert (!ctrl.reg_write) else $error("R-type funct %h writes a register", inst);
  end

endmodule

//--- logic/rv32i_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer register file, written from writeback, read in decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_regfile (
  input  logic                 clk,
  input  logic                 we,
  input  rv32i_pkg::reg_addr_t rd,
  input  rv32i_pkg::word_t     rd_data,
  input  rv32i_pkg::reg_addr_t rs1,
  input  rv32i_pkg::reg_addr_t rs2,
  output rv32i_pkg::word_t     rs1_data,
  output rv32i_pkg::word_t     rs2_data
);
  import rv32i_pkg::*;

  word_t regs [1:31];   // x0 has no storage

  always_ff @(posedge clk)
  begin
    if (we && rd != '0)
      regs[rd] <= rd_data;
  end

  // Same-cycle write is not visible here, decode forwards from writeback
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  a_we_known: assert property (@(posedge clk) !$isunknown(we))
    else $error("Register file write enable unknown");

endmodule

//--- logic/rv32i_hazard_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode-stage forwarding select and load-use stall detection
// Compares decode sources against the three later pipeline registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_hazard_unit (
  input  rv32i_pkg::reg_addr_t rs1,
  input  rv32i_pkg::reg_addr_t rs2,
  input  rv32i_pkg::id_ex_t    id_ex,
  input  rv32i_pkg::ex_mem_t   ex_mem,
  input  rv32i_pkg::mem_wb_t   mem_wb,
  output rv32i_pkg::fwd_sel_t  fwd_rs1,
  output rv32i_pkg::fwd_sel_t  fwd_rs2,
  output logic                 stall
);
  import rv32i_pkg::*;

  logic load_in_ex;

  // Youngest producer wins
  function automatic fwd_sel_t pick_src(input reg_addr_t rs);
    fwd_sel_t sel;
    sel = FWD_RF;
    if (rs == '0)
      sel = FWD_RF;
    else if (id_ex.ctrl.reg_write && !id_ex.ctrl.mem_read && id_ex.rd == rs)
      sel = FWD_EX;      // Loads in execute are covered by the stall
    else if (ex_mem.reg_write && ex_mem.mem_read && ex_mem.rd == rs)
      sel = FWD_MEM_LOAD;
    else if (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == rs)
      sel = FWD_MEM_ALU;
    else if (mem_wb.reg_write && mem_wb.rd == rs)
      sel = FWD_WB;
    return sel;
  endfunction

  always_comb
  begin
    fwd_rs1 = pick_src(rs1);
    fwd_rs2 = pick_src(rs2);
  end

  assign load_in_ex = id_ex.ctrl.mem_read && (id_ex.rd != '0);

  // Load data is not ready until the memory stage
  assign stall = load_in_ex && (id_ex.rd == rs1 || id_ex.rd == rs2);

  // A stall only ever waits for a load that writes a register
  always_comb
  begin
    if (stall)
      assert (id_ex.ctrl.mem_read && id_ex.ctrl.reg_write)
        else $error("Stall without a register-writing load in execute");
  end

endmodule

//--- logic/rv32i_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute-stage ALU, combinational
// Also forms load and store addresses and the lui result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_alu (
  input  rv32i_pkg::word_t   a,
  input  rv32i_pkg::word_t   b,
  input  rv32i_pkg::alu_op_t op,
  output rv32i_pkg::word_t   result
);
  import rv32i_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];   // RV32 shifts use five bits only

  always_comb
  begin
    case (op)
      ALU_ADD:
        result = a + b;
      ALU_SUB:
        result = a - b;
      ALU_AND:
        result = a & b;
      ALU_OR:
        result = a | b;
      ALU_XOR:
        result = a ^ b;
      ALU_SLL:
        result = a << shamt;
      default:
        result = '0;   // Unused codes
    endcase
  end

endmodule

//--- logic/rv32i_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Five-stage in-order RV32I core, top level
// Instruction and data memories sit outside and answer in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_cpu (
  input  logic                 clk,
  input  logic                 reset,
  output rv32i_pkg::word_t     pc,
  input  rv32i_pkg::word_t     inst,
  output rv32i_pkg::dmem_req_t dmem_req,
  input  rv32i_pkg::word_t     mem_rdata
);
  import rv32i_pkg::*;

  word_t     if_id_inst;
  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  reg_addr_t id_rd;
  ctrl_t     id_ctrl;
  word_t     id_imm;
  word_t     rf_rs1_data;
  word_t     rf_rs2_data;
  fwd_sel_t  fwd_rs1;
  fwd_sel_t  fwd_rs2;
  logic      stall;
  word_t     id_rs1_data;
  word_t     id_rs2_data;
  id_ex_t    id_ex_next;
  id_ex_t    id_ex;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;
  word_t     wb_load_data;
  word_t     wb_value;

  // Fetch
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= '0;
    else if (!stall)
      pc <= pc + PC_STEP;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      if_id_inst <= '0;     // All-zero word decodes as a bubble
    else if (!stall)
      if_id_inst <= inst;
  end

  // Decode
  assign id_rs1 = if_id_inst[19:15];
  assign id_rs2 = if_id_inst[24:20];
  assign id_rd  = if_id_inst[11:7];

  rv32i_decoder u_decoder (
    .inst (if_id_inst),
    .ctrl (id_ctrl),
    .imm  (id_imm)
  );

  rv32i_regfile u_regfile (
    .clk      (clk),
    .we       (mem_wb.reg_write),
    .rd       (mem_wb.rd),
    .rd_data  (wb_value),
    .rs1      (id_rs1),
    .rs2      (id_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  rv32i_hazard_unit u_hazard_unit (
    .rs1     (id_rs1),
    .rs2     (id_rs2),
    .id_ex   (id_ex),
    .ex_mem  (ex_mem),
    .mem_wb  (mem_wb),
    .fwd_rs1 (fwd_rs1),
    .fwd_rs2 (fwd_rs2),
    .stall   (stall)
  );

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val);
    word_t val;
    case (sel)
      FWD_EX:       val = alu_result;
      FWD_MEM_LOAD: val = mem_rdata;
      FWD_MEM_ALU:  val = ex_mem.alu_result;
      FWD_WB:       val = wb_value;
      default:      val = rf_val;
    endcase
    return val;
  endfunction

  always_comb
  begin
    id_rs1_data = fwd_mux(fwd_rs1, rf_rs1_data);
    id_rs2_data = fwd_mux(fwd_rs2, rf_rs2_data);
  end

  always_comb
  begin
    id_ex_next = '{ctrl: id_ctrl, rd: id_rd, rs1_data: id_rs1_data,
                   rs2_data: id_rs2_data, imm: id_imm};
    if (stall)
      id_ex_next.ctrl = '0;   // Load-use bubble
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else
      id_ex <= id_ex_next;
  end

  // Execute
  assign alu_a = id_ex.ctrl.lui ? '0 : id_ex.rs1_data;
  assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.rs2_data;

  rv32i_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (id_ex.ctrl.alu_op),
    .result (alu_result)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
      ex_mem <= '{mem_read: id_ex.ctrl.mem_read, mem_write: id_ex.ctrl.mem_write,
                  reg_write: id_ex.ctrl.reg_write, rd: id_ex.rd,
                  alu_result: alu_result, store_data: id_ex.rs2_data};
  end

  // Memory, read data comes back in this same cycle
  assign dmem_req = '{write: ex_mem.mem_write, addr: ex_mem.alu_result,
                      wdata: ex_mem.store_data};

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_wb <= '0;
    else
      mem_wb <= '{reg_write: ex_mem.reg_write, mem_to_reg: ex_mem.mem_read,
                  rd: ex_mem.rd, result: ex_mem.alu_result};
  end

  always_ff @(posedge clk)
  begin
    wb_load_data <= mem_rdata;
  end

  // Writeback
  assign wb_value = mem_wb.mem_to_reg ? wb_load_data : mem_wb.result;

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc %h not word aligned", pc);

endmodule

//--- verification/rv32i_cpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV32I core with instruction and data memory models
// Loads the program and the expected store list from the pattern file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_cpu_tb;
  import rv32i_pkg::*;

  localparam int          CLK_PERIOD   = 40;
  localparam logic [31:0] SEED         = 32'h1751_31ca;
  localparam int          RESET_CYCLES = 4;
  localparam int          IMEM_DEPTH   = 64;
  localparam int          DMEM_DEPTH   = 64;
  localparam int          MAX_STORES   = 32;
  localparam int          QUIET_CYCLES = 20;   // No store may follow the last expected one
  localparam string       PATTERN_FILE = "verification/rv32i_patterns.txt";

  logic        clk;
  logic        reset;
  word_t       pc;
  word_t       inst;
  dmem_req_t   dmem_req;
  word_t       mem_rdata;

  word_t       imem [0:IMEM_DEPTH-1];
  word_t       dmem [0:DMEM_DEPTH-1];
  word_t       exp_addr [0:MAX_STORES-1];
  word_t       exp_data [0:MAX_STORES-1];
  string       exp_name [0:MAX_STORES-1];
  logic [31:0] prog_len;
  int          exp_count;
  int          store_idx;

  rv32i_cpu u_rv32i_cpu (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .dmem_req  (dmem_req),
    .mem_rdata (mem_rdata)
  );

  // Fetches past the program see an all-zero word
  assign inst      = ({2'b00, pc[31:2]} < prog_len) ? imem[pc[7:2]] : '0;
  assign mem_rdata = (dmem_req.addr[31:8] == '0) ? dmem[dmem_req.addr[7:2]] : '0;

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1)
      c = $fgetc(fd);
  endtask

  task automatic load_patterns();
    int    fd;
    int    code;
    string tag;
    string name;
    word_t addr;
    word_t data;
    fd = $fopen(PATTERN_FILE, "r");
    assert (fd != 0) else report_failure("Cannot open the pattern file");
    for (int i = 0; i < DMEM_DEPTH; i++)
      dmem[i] <= 32'h5a5a_0000 ^ (i << 2);   // Background tied to the byte address
    while (!$feof(fd))
    begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1)
        break;
      if (tag == "#")
        skip_line(fd);
      else if (tag == "I")
      begin
        code = $fscanf(fd, "%h", data);
        assert (prog_len < IMEM_DEPTH) else report_failure("Program exceeds instruction memory");
        imem[prog_len[5:0]] = data;
        prog_len = prog_len + 1;
      end
      else if (tag == "S")
      begin
        code = $fscanf(fd, "%h %h %s", addr, data, name);
        assert (exp_count < MAX_STORES) else report_failure("Too many expected stores");
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_name[exp_count] = name;
        exp_count++;
      end
      else if (tag == "D")
      begin
        code = $fscanf(fd, "%h %h", addr, data);
        dmem[addr[7:2]] <= data;   // Initial data memory contents
      end
      else
        report_failure($sformatf("Unknown tag %s in the pattern file", tag));
    end
    $fclose(fd);
  endtask

  // Each store must match the next entry, in program order
  task automatic check_store();
    assert (store_idx < exp_count) else report_failure("Store seen after the last expected one");
    assert (dmem_req.addr == exp_addr[store_idx])
      else report_failure($sformatf("Mismatch %s address: expected %h, actual %h",
                                    exp_name[store_idx], exp_addr[store_idx], dmem_req.addr));
    assert (dmem_req.wdata == exp_data[store_idx])
      else report_failure($sformatf("Mismatch %s data: expected %h, actual %h",
                                    exp_name[store_idx], exp_data[store_idx], dmem_req.wdata));
    store_idx++;
  endtask

  initial
  begin
    logic [31:0] rnd;
    int          extra_reset;
    int          cycles;
    int          quiet;
    int          cycle_limit;
    reset     = 1'b1;
    prog_len  = '0;
    exp_count = 0;
    store_idx = 0;
    cycles    = 0;
    quiet     = 0;
    for (int i = 0; i < IMEM_DEPTH; i++)
      imem[i] = '0;
    load_patterns();
    cycle_limit = 2 * prog_len + 40;
    rnd         = xorshift32(SEED);
    extra_reset = rnd % 4;   // Shifts the release edge by 0 to 3 cycles
    repeat (RESET_CYCLES + extra_reset)
    begin
      @(posedge clk);
      assert (dmem_req.write == 1'b0) else report_failure("Store strobe raised during reset");
      assert (pc == 32'h0)
        else report_failure($sformatf("Mismatch reset_pc: expected %h, actual %h",
                                      32'h0, pc));
    end
    reset <= 1'b0;
    while (quiet < QUIET_CYCLES && cycles < cycle_limit)
    begin
      @(posedge clk);
      cycles++;
      assert (!$isunknown(dmem_req.write)) else report_failure("Store strobe is unknown");
      if (dmem_req.write)
      begin
        check_store();
        dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
      end
      else if (store_idx == exp_count)
        quiet++;
    end
    if (quiet >= QUIET_CYCLES)
    begin
      $display("Verification passed");
      $finish;
    end
    else
      report_failure($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                               cycles, store_idx, exp_count));
  end

endmodule

//--- all.f
logic/rv32i_pkg.sv
logic/rv32i_decoder.sv
logic/rv32i_regfile.sv
logic/rv32i_hazard_unit.sv
logic/rv32i_alu.sv
logic/rv32i_cpu.sv
verification/rv32i_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the RV32I core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module rv32i_cpu_tb -o rv32i_sim &&
  ./obj_dir/rv32i_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "Verification failed" sim.log && exit 1
grep -qs "Verification passed" sim.log || exit 1
exit 0

//--- verification/rv32i_patterns.txt
# I <instruction word> | D <byte address> <initial data>
# S <byte address> <store data> <test name>, stores in program order
D 00000080 12345678
I 06c00093
I 03500113
I 002081b3
I 40110233
I 0041f2b3
I 0021e333
I 00602023
I 00502223
I 00402423
I 00302623
I 0ff1c393
I 7003e413
I 00702823
I 0f047493
I 01449513
I 00802a23
I 00902c23
I 00a02e23
I abcde5b7
I 02b02023
I 12300013
I 02002223
I 08002603
I 01060693
I 02d02423
I 00802703
I 02e02623
I 02e02823
S 00000000 000000b5 or_fwd_ex
S 00000004 00000081 and_fwd_wb
S 00000008 ffffffc9 sub_rf
S 0000000c 000000a1 add_rf
S 00000010 0000005e xori_fwd_mem
S 00000014 0000075e ori_rf
S 00000018 00000050 andi_fwd_wb
S 0000001c 05000000 slli_fwd_wb
S 00000020 abcde000 lui_fwd_ex
S 00000024 00000000 x0_write_ignored
S 00000028 12345688 lw_use_stall
S 0000002c ffffffc9 lw_stored_mem
S 00000030 ffffffc9 lw_stored_wb
